/* design/rom_mem_pkg.sv */
/*
 * SDRAM geometry and read burst timing shared by the controller, the arbiter
 * and the top level. Import it where the constants size ports or time bursts.
 */
package rom_mem_pkg;

    // address width in 16-bit sdram words
    localparam int sdram_aw = 22;

    // edges from the mem_rd launch edge to the edge that samples the first word
    // the second word is sampled one edge later
    localparam int mem_lat = 2;

    // words per read burst that fill one 32-bit line
    localparam int burst_len = 2;

endpackage

/* design/rom_data_pkg.sv */
/*
 * Cache line layout and data-width helpers for the read slots.
 * A slot imports this to decode its one-line cache.
 */
package rom_data_pkg;

    // one cached line holds two sdram words
    localparam int line_w = 32;

    // same 32 bits seen as bytes or halfwords
    // little endian so byte 0 and halfword 0 sit in bits 7:0 and 15:0
    typedef union packed {
        logic [line_w/8-1:0][7:0]   b;
        logic [line_w/16-1:0][15:0] h;
    } cache_line_t;

    // low address bits that pick the item inside a line
    function automatic int line_aw_shift(input int dw);
        int sh;
        case (dw)
            8:       sh = 2;
            16:      sh = 1;
            default: sh = 0;
        endcase
        return sh;
    endfunction

endpackage

/* design/rom_slot_req.sv */
/*
 * One read slot that maps a consumer address into sdram words, keeps the last
 * line fetched and requests a two-word burst on a miss. Consumer holds cs and addr.
 */
`timescale 1ns/1ps

module rom_slot_req #(
    parameter int aw = 12,
    parameter int dw = 8,
    parameter logic [rom_mem_pkg::sdram_aw-1:0] offset = '0
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cs,
    input  logic [aw-1:0]                    addr,
    input  logic                             ack,
    input  logic                             dst,
    input  logic                             rdy,
    input  logic [15:0]                      data_read,
    output logic [dw-1:0]                    dout,
    output logic                             ok,
    output logic                             req,
    output logic [rom_mem_pkg::sdram_aw-1:0] sdram_addr
);
    import rom_data_pkg::*;

    // in-line select bits for this width
    localparam int sh = line_aw_shift(dw);
    localparam int saw = $bits(offset);

    cache_line_t     line;
    cache_line_t     line_nx;
    logic [aw-1:0]   line_idx;
    logic [saw-1:0]  word_addr;
    logic [dw-1:0]   dout_nx;
    logic            valid;
    logic            valid_nx;
    logic            hit_nx;
    logic            busy;
    logic            issue;

    // line number with two sdram words per line
    assign line_idx  = addr >> sh;
    assign word_addr = offset + (saw'(line_idx) << 1);

    // line as it will be after this edge
    // low half lands on dst and high half on rdy
    always_comb begin
        line_nx  = line;
        valid_nx = valid;
        if (dst) begin
            line_nx.h[0] = data_read;
        end
        if (rdy) begin
            line_nx.h[1] = data_read;
            valid_nx     = 1'b1;
        end
    end

    // sdram_addr doubles as the tag of the cached line
    assign hit_nx = valid_nx && (sdram_addr == word_addr);

    // new burst only once the previous one is fully back
    assign issue = cs && !hit_nx && !busy;

    // pick the item out of the line through the matching view
    generate
        if (dw == 8) begin : g_byte
            assign dout_nx = line_nx.b[addr[sh-1:0]];
        end else if (dw == 16) begin : g_half
            assign dout_nx = line_nx.h[addr[sh-1:0]];
        end else begin : g_word
            assign dout_nx = line_nx;
        end
    endgenerate

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            req   <= 1'b0;
            busy  <= 1'b0;
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            // ok tracks the address every cycle and drops as soon as it moves
            ok    <= cs && hit_nx;
            valid <= valid_nx;
            // req lasts until the arbiter acknowledges
            if (ack) begin
                req <= 1'b0;
            end
            if (rdy) begin
                busy <= 1'b0;
            end
            if (issue) begin
                req   <= 1'b1;
                busy  <= 1'b1;
                // the line is refilled in place
                valid <= 1'b0;
            end
        end
    end

    // line data, tag and output word
    always_ff @(posedge clk) begin
        line <= line_nx;
        dout <= dout_nx;
        if (issue) begin
            sdram_addr <= word_addr;
        end
    end

endmodule

/* design/rom_slot_arbiter.sv */
/*
 * Round-robin arbiter between two read slots in front of one sdram controller.
 * Forwards the winner's request and steers ack, dst and rdy back to it.
 */
`timescale 1ns/1ps

module rom_slot_arbiter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             slot0_req,
    input  logic [rom_mem_pkg::sdram_aw-1:0] slot0_addr,
    input  logic                             slot1_req,
    input  logic [rom_mem_pkg::sdram_aw-1:0] slot1_addr,
    input  logic                             ack,
    input  logic                             dst,
    input  logic                             rdy,
    output logic                             slot0_ack,
    output logic                             slot0_dst,
    output logic                             slot0_rdy,
    output logic                             slot1_ack,
    output logic                             slot1_dst,
    output logic                             slot1_rdy,
    output logic                             req,
    output logic [rom_mem_pkg::sdram_aw-1:0] addr
);
    // last is the slot served last time
    // gnt is the slot whose request is waiting for ack
    // owner is the slot whose burst is in flight
    logic last;
    logic pend;
    logic gnt;
    logic owner;
    logic owner_vld;
    logic pick;
    logic sel;

    // on a tie go to the slot not served last
    always_comb begin
        if (slot0_req && slot1_req) begin
            pick = ~last;
        end else begin
            pick = slot1_req;
        end
    end

    // choice is frozen once the request is out
    assign sel  = pend ? gnt : pick;
    assign req  = pend || ((slot0_req || slot1_req) && !owner_vld);
    assign addr = sel ? slot1_addr : slot0_addr;

    // ack belongs to the pending grant
    assign slot0_ack = ack && pend && !gnt;
    assign slot1_ack = ack && pend && gnt;

    // burst flags only reach the owner
    assign slot0_dst = dst && owner_vld && !owner;
    assign slot0_rdy = rdy && owner_vld && !owner;
    assign slot1_dst = dst && owner_vld && owner;
    assign slot1_rdy = rdy && owner_vld && owner;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            // slot 0 wins the first tie
            last      <= 1'b1;
            pend      <= 1'b0;
            gnt       <= 1'b0;
            owner     <= 1'b0;
            owner_vld <= 1'b0;
        end else begin
            // controller is idle whenever nothing is pending or owned
            if (!pend && !owner_vld && (slot0_req || slot1_req)) begin
                pend <= 1'b1;
                gnt  <= pick;
            end
            if (ack) begin
                pend      <= 1'b0;
                owner     <= gnt;
                owner_vld <= 1'b1;
                last      <= gnt;
            end
            if (rdy) begin
                owner_vld <= 1'b0;
            end
        end
    end

endmodule

/* design/sdram_rd_ctrl.sv */
/*
 * Read-only sdram sequencer that takes one request when idle, strobes the memory
 * port and returns the two burst words marked by dst and rdy.
 */
`timescale 1ns/1ps

module sdram_rd_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req,
    input  logic [rom_mem_pkg::sdram_aw-1:0] addr,
    input  logic [15:0]                      mem_data,
    output logic                             ack,
    output logic                             dst,
    output logic                             rdy,
    output logic [15:0]                      data_read,
    output logic                             mem_rd,
    output logic [rom_mem_pkg::sdram_aw-1:0] mem_addr
);
    import rom_mem_pkg::*;

    localparam int cnt_w  = (mem_lat > 1) ? $clog2(mem_lat) : 1;
    localparam int beat_w = (burst_len > 1) ? $clog2(burst_len) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_data
    } state_t;

    state_t            state;
    logic [cnt_w-1:0]  cnt;
    logic [beat_w-1:0] beat;
    logic              take;
    logic              sample;

    // accept only from idle since the arbiter holds req until ack
    assign take = (state == st_idle) && req;

    // mem_data carries a burst word on the last wait edge and each data edge
    assign sample = ((state == st_wait) && (cnt == '0)) || (state == st_data);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            ack    <= 1'b0;
            mem_rd <= 1'b0;
            dst    <= 1'b0;
            rdy    <= 1'b0;
            cnt    <= '0;
            beat   <= '0;
        end else begin
            // all strobes are single cycle
            ack    <= 1'b0;
            mem_rd <= 1'b0;
            dst    <= 1'b0;
            rdy    <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        // ack and mem_rd go out together
                        ack    <= 1'b1;
                        mem_rd <= 1'b1;
                        cnt    <= cnt_w'(mem_lat - 1);
                        state  <= st_wait;
                    end
                end
                st_wait: begin
                    if (cnt == '0) begin
                        // first word
                        dst   <= 1'b1;
                        beat  <= beat_w'(1);
                        state <= st_data;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                st_data: begin
                    beat <= beat + 1'b1;
                    // last word of the burst and free again next cycle
                    if (beat == beat_w'(burst_len - 1)) begin
                        rdy   <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address and returned data
    always_ff @(posedge clk) begin
        if (take) begin
            mem_addr <= addr;
        end
        if (sample) begin
            data_read <= mem_data;
        end
    end

endmodule

/* design/rom_2slot_sys.sv */
/*
 * Two read slots sharing one read-only sdram through a round-robin arbiter.
 * Consumers hold cs and addr until ok; the memory port has a fixed latency.
 */
`timescale 1ns/1ps

module rom_2slot_sys #(
    parameter int slot0_aw = 12,
    parameter int slot0_dw = 8,
    parameter int slot1_aw = 10,
    parameter int slot1_dw = 32,
    parameter logic [rom_mem_pkg::sdram_aw-1:0] slot0_offset = '0,
    parameter logic [rom_mem_pkg::sdram_aw-1:0] slot1_offset = 22'h10000
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             slot0_cs,
    input  logic [slot0_aw-1:0]              slot0_addr,
    input  logic                             slot1_cs,
    input  logic [slot1_aw-1:0]              slot1_addr,
    input  logic [15:0]                      mem_data,
    output logic [slot0_dw-1:0]              slot0_dout,
    output logic                             slot0_ok,
    output logic [slot1_dw-1:0]              slot1_dout,
    output logic                             slot1_ok,
    output logic                             mem_rd,
    output logic [rom_mem_pkg::sdram_aw-1:0] mem_addr
);
    import rom_mem_pkg::*;

    // slot side of the arbiter
    logic                s0_req;
    logic                s0_ack;
    logic                s0_dst;
    logic                s0_rdy;
    logic [sdram_aw-1:0] s0_addr;
    logic                s1_req;
    logic                s1_ack;
    logic                s1_dst;
    logic                s1_rdy;
    logic [sdram_aw-1:0] s1_addr;

    // controller side
    logic                ctl_req;
    logic                ctl_ack;
    logic                ctl_dst;
    logic                ctl_rdy;
    logic [sdram_aw-1:0] ctl_addr;
    logic [15:0]         data_read;

    // byte-wide slot at the bottom of sdram
    rom_slot_req #(
        .aw     (slot0_aw),
        .dw     (slot0_dw),
        .offset (slot0_offset)
    ) u_slot0 (
        .clk        (clk),
        .rst        (rst),
        .cs         (slot0_cs),
        .addr       (slot0_addr),
        .ack        (s0_ack),
        .dst        (s0_dst),
        .rdy        (s0_rdy),
        .data_read  (data_read),
        .dout       (slot0_dout),
        .ok         (slot0_ok),
        .req        (s0_req),
        .sdram_addr (s0_addr)
    );

    // word-wide slot in its own region
    rom_slot_req #(
        .aw     (slot1_aw),
        .dw     (slot1_dw),
        .offset (slot1_offset)
    ) u_slot1 (
        .clk        (clk),
        .rst        (rst),
        .cs         (slot1_cs),
        .addr       (slot1_addr),
        .ack        (s1_ack),
        .dst        (s1_dst),
        .rdy        (s1_rdy),
        .data_read  (data_read),
        .dout       (slot1_dout),
        .ok         (slot1_ok),
        .req        (s1_req),
        .sdram_addr (s1_addr)
    );

    rom_slot_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .slot0_req  (s0_req),
        .slot0_addr (s0_addr),
        .slot1_req  (s1_req),
        .slot1_addr (s1_addr),
        .ack        (ctl_ack),
        .dst        (ctl_dst),
        .rdy        (ctl_rdy),
        .slot0_ack  (s0_ack),
        .slot0_dst  (s0_dst),
        .slot0_rdy  (s0_rdy),
        .slot1_ack  (s1_ack),
        .slot1_dst  (s1_dst),
        .slot1_rdy  (s1_rdy),
        .req        (ctl_req),
        .addr       (ctl_addr)
    );

    sdram_rd_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (ctl_req),
        .addr      (ctl_addr),
        .mem_data  (mem_data),
        .ack       (ctl_ack),
        .dst       (ctl_dst),
        .rdy       (ctl_rdy),
        .data_read (data_read),
        .mem_rd    (mem_rd),
        .mem_addr  (mem_addr)
    );

endmodule

/* verif/sdram_word_model.sv */
/*
 * Behavioral read-only sdram for the testbench. Answers each mem_rd strobe
 * with a two-word burst where word a holds the low 16 bits of a xor 16'h5a3c.
 */
`timescale 1ns/1ps

module sdram_word_model (
    input  logic                             clk,
    input  logic                             mem_rd,
    input  logic [rom_mem_pkg::sdram_aw-1:0] mem_addr,
    output logic [15:0]                      mem_data
);
    import rom_mem_pkg::*;

    // age counts edges since the strobe was seen and is zero when idle
    logic [sdram_aw-1:0] base;
    int                  age = 0;

    function automatic logic [15:0] word_at(input logic [sdram_aw-1:0] a);
        return a[15:0] ^ 16'h5a3c;
    endfunction

    always @(posedge clk) begin
        if (mem_rd) begin
            base <= mem_addr;
            age  <= 1;
        end else if (age != 0) begin
            // burst over after the last word has been on the bus
            age <= (age >= mem_lat + burst_len - 2) ? 0 : age + 1;
        end
    end

    // first word is sampled mem_lat edges after the launch edge
    always_comb begin
        if (age >= mem_lat - 1 && age < mem_lat - 1 + burst_len) begin
            mem_data = word_at(base + sdram_aw'(age - (mem_lat - 1)));
        end else begin
            mem_data = '0;
        end
    end

endmodule

/* verif/rom_2slot_sys_tb.sv */
/*
 * Testbench for the two-slot sdram reader. Drives both consumer ports,
 * checks data, latency and round-robin order against a reference model.
 */
`timescale 1ns/1ps

module rom_2slot_sys_tb;
    import rom_mem_pkg::*;
    import rom_data_pkg::*;

    localparam int slot0_aw = 12;
    localparam int slot0_dw = 8;
    localparam int slot1_aw = 10;
    localparam int slot1_dw = 32;
    localparam logic [sdram_aw-1:0] slot1_offset = 22'h10000;

    localparam int reset_cycles = 8;
    localparam int miss_lat     = 6;
    localparam int hit_lat      = 1;
    localparam int wait_limit   = 40;

    // each pair round also has one solo read
    localparam int n_slot0 = 32;
    localparam int n_slot1 = 16;
    localparam int n_hits  = 4;
    localparam int n_pairs = 8;
    localparam int n_reads = n_slot0 + n_slot1 + n_hits + 3 * n_pairs + 2;
    // worst read is a contended miss plus idle gap
    localparam int read_cost   = 12;
    localparam int cycle_limit = 4 * (2 * reset_cycles + n_reads * read_cost + 32);

    logic                clk;
    logic                rst;
    logic                slot0_cs;
    logic [slot0_aw-1:0] slot0_addr;
    logic                slot1_cs;
    logic [slot1_aw-1:0] slot1_addr;
    logic [15:0]         mem_data;
    logic [slot0_dw-1:0] slot0_dout;
    logic                slot0_ok;
    logic [slot1_dw-1:0] slot1_dout;
    logic                slot1_ok;
    logic                mem_rd;
    logic [sdram_aw-1:0] mem_addr;

    integer seed;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycles = 0;
    // one entry per mem_rd strobe that is 1 when it hit slot 1's region
    bit     region_log[$];

    // address seen at the previous edge that ok and dout refer to
    logic [slot0_aw-1:0] prev0_addr;
    logic [slot1_aw-1:0] prev1_addr;

    // reference copy of each slot's cached line
    bit                  line0_valid;
    logic [slot0_aw-1:2] line0_tag;
    bit                  line1_valid;
    logic [slot1_aw-1:0] line1_tag;

    function automatic logic [15:0] mem_word(input logic [sdram_aw-1:0] a);
        return a[15:0] ^ 16'h5a3c;
    endfunction

    // little endian line with the lower word in the low half
    function automatic logic [31:0] line_at(input logic [sdram_aw-1:0] w);
        return {mem_word(w + sdram_aw'(1)), mem_word(w)};
    endfunction

    function automatic logic [7:0] exp_byte(input logic [slot0_aw-1:0] a);
        cache_line_t line;
        line = line_at(sdram_aw'({a[slot0_aw-1:2], 1'b0}));
        return line.b[a[1:0]];
    endfunction

    function automatic logic [31:0] exp_word(input logic [slot1_aw-1:0] a);
        return line_at(slot1_offset + sdram_aw'({a, 1'b0}));
    endfunction

    rom_2slot_sys #(
        .slot0_aw     (slot0_aw),
        .slot0_dw     (slot0_dw),
        .slot1_aw     (slot1_aw),
        .slot1_dw     (slot1_dw),
        .slot0_offset ('0),
        .slot1_offset (slot1_offset)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .slot0_cs   (slot0_cs),
        .slot0_addr (slot0_addr),
        .slot1_cs   (slot1_cs),
        .slot1_addr (slot1_addr),
        .mem_data   (mem_data),
        .slot0_dout (slot0_dout),
        .slot0_ok   (slot0_ok),
        .slot1_dout (slot1_dout),
        .slot1_ok   (slot1_ok),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr)
    );

    sdram_word_model u_mem (
        .clk      (clk),
        .mem_rd   (mem_rd),
        .mem_addr (mem_addr),
        .mem_data (mem_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        prev0_addr <= slot0_addr;
        prev1_addr <= slot1_addr;
    end

    // which region each burst went to
    always @(posedge clk) begin
        if (mem_rd) begin
            region_log.push_back(mem_addr >= slot1_offset);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, run stopped", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    data0_check: assert property (@(posedge clk) disable iff (rst)
        slot0_ok |-> slot0_dout == exp_byte(prev0_addr))
    else begin
        errors++;
        $display("MISMATCH slot0_dout expected %h got %h",
                 exp_byte($sampled(prev0_addr)), $sampled(slot0_dout));
    end

    data1_check: assert property (@(posedge clk) disable iff (rst)
        slot1_ok |-> slot1_dout == exp_word(prev1_addr))
    else begin
        errors++;
        $display("MISMATCH slot1_dout expected %h got %h",
                 exp_word($sampled(prev1_addr)), $sampled(slot1_dout));
    end

    // ok one cycle after the last burst word
    rdy0_check: assert property (@(posedge clk) disable iff (rst)
        dut0.s0_rdy && slot0_cs |=> slot0_ok)
    else begin
        errors++;
        $display("slot 0 ok did not rise the cycle after its rdy");
    end

    rdy1_check: assert property (@(posedge clk) disable iff (rst)
        dut0.s1_rdy && slot1_cs |=> slot1_ok)
    else begin
        errors++;
        $display("slot 1 ok did not rise the cycle after its rdy");
    end

    // quiet during reset and on the first edge after it
    reset_check: assert property (@(posedge clk)
        (rst || $past(rst)) |-> !mem_rd && !slot0_ok && !slot1_ok)
    else begin
        errors++;
        $display("mem_rd or an ok was high during or right after reset");
    end

    task automatic expect_equal(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("MISMATCH %s expected %0h got %0h", what, expected, actual);
        end
    endtask

    // lat counts falling edges until ok is seen
    task automatic wait_ok(input int slot, output int lat);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!(slot == 0 ? slot0_ok : slot1_ok) && lat < wait_limit);
        assert (slot == 0 ? slot0_ok : slot1_ok) else begin
            errors++;
            $display("slot %0d got no ok within %0d cycles", slot, wait_limit);
        end
    endtask

    function automatic logic [slot0_aw-1:0] fresh_addr0();
        logic [slot0_aw-1:0] a;
        a = slot0_aw'($random(seed));
        // force a different line than the cached one
        if (line0_valid && a[slot0_aw-1:2] == line0_tag) begin
            a = a ^ slot0_aw'(12'h400);
        end
        return a;
    endfunction

    function automatic logic [slot1_aw-1:0] fresh_addr1();
        logic [slot1_aw-1:0] a;
        a = slot1_aw'($random(seed));
        if (line1_valid && a == line1_tag) begin
            a = a ^ slot1_aw'(1);
        end
        return a;
    endfunction

    task automatic read_slot0(input logic [slot0_aw-1:0] a);
        int lat;
        int exp_lat;
        exp_lat = (line0_valid && line0_tag == a[slot0_aw-1:2]) ? hit_lat : miss_lat;
        slot0_cs   = 1'b1;
        slot0_addr = a;
        wait_ok(0, lat);
        expect_equal("slot0_ok latency", exp_lat, lat);
        line0_valid = 1'b1;
        line0_tag   = a[slot0_aw-1:2];
        slot0_cs    = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_slot1(input logic [slot1_aw-1:0] a);
        int lat;
        int exp_lat;
        exp_lat = (line1_valid && line1_tag == a) ? hit_lat : miss_lat;
        slot1_cs   = 1'b1;
        slot1_addr = a;
        wait_ok(1, lat);
        expect_equal("slot1_ok latency", exp_lat, lat);
        line1_valid = 1'b1;
        line1_tag   = a;
        slot1_cs    = 1'b0;
        @(negedge clk);
    endtask

    // both slots miss in the same cycle
    task automatic read_pair(input logic [slot0_aw-1:0] a0, input logic [slot1_aw-1:0] a1);
        int base;
        int n;
        bit seen0;
        bit seen1;
        bit first_exp;
        base = region_log.size();
        // tie goes to the slot that did not strobe last
        first_exp = !region_log[base - 1];
        seen0 = 1'b0;
        seen1 = 1'b0;
        n = 0;
        slot0_cs   = 1'b1;
        slot0_addr = a0;
        slot1_cs   = 1'b1;
        slot1_addr = a1;
        while (!(seen0 && seen1) && n < wait_limit) begin
            @(negedge clk);
            n++;
            if (slot0_ok) begin
                seen0    = 1'b1;
                slot0_cs = 1'b0;
            end
            if (slot1_ok) begin
                seen1    = 1'b1;
                slot1_cs = 1'b0;
            end
        end
        assert (seen0 && seen1) else begin
            errors++;
            $display("contended reads did not both finish within %0d cycles", wait_limit);
        end
        expect_equal("mem_rd strobe count", 2, region_log.size() - base);
        if (region_log.size() - base == 2) begin
            expect_equal("first burst mem_addr region", 32'(first_exp),
                         32'(region_log[base]));
            expect_equal("second burst mem_addr region", 32'(!first_exp),
                         32'(region_log[base + 1]));
        end
        line0_valid = 1'b1;
        line0_tag   = a0[slot0_aw-1:2];
        line1_valid = 1'b1;
        line1_tag   = a1;
        slot0_cs    = 1'b0;
        slot1_cs    = 1'b0;
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: pass", name);
        end
    endtask

    initial begin
        int e;
        int i;
        int n;
        int lat;
        logic [slot0_aw-1:0] a0;
        seed        = 32'hb49e869d;
        rst         = 1'b1;
        slot0_cs    = 1'b0;
        slot0_addr  = '0;
        slot1_cs    = 1'b0;
        slot1_addr  = '0;
        line0_valid = 1'b0;
        line0_tag   = '0;
        line1_valid = 1'b0;
        line1_tag   = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        e = errors;
        for (i = 0; i < n_slot0; i++) begin
            read_slot0(slot0_aw'($random(seed)));
        end
        report_test("slot0_random_bytes", e);

        e = errors;
        for (i = 0; i < n_slot1; i++) begin
            read_slot1(slot1_aw'($random(seed)));
        end
        report_test("slot1_words", e);

        // other bytes of one line need no new bursts
        e = errors;
        a0 = fresh_addr0();
        read_slot0(a0);
        for (i = 1; i < n_hits; i++) begin
            n = region_log.size();
            read_slot0(a0 ^ slot0_aw'(i));
            expect_equal("mem_rd strobe count on hit", 0, region_log.size() - n);
        end
        report_test("slot0_line_hits", e);

        // solo read first so the pair order flips
        e = errors;
        for (i = 0; i < n_pairs; i++) begin
            if (i % 2 == 0) begin
                read_slot0(fresh_addr0());
            end else begin
                read_slot1(fresh_addr1());
            end
            read_pair(fresh_addr0(), fresh_addr1());
        end
        report_test("both_slots_round_robin", e);

        // second reset mid run with both consumers sitting on cached lines
        e = errors;
        slot0_cs   = 1'b1;
        slot0_addr = {line0_tag, 2'b00};
        slot1_cs   = 1'b1;
        slot1_addr = line1_tag;
        rst        = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst         = 1'b0;
        slot1_cs    = 1'b0;
        line0_valid = 1'b0;
        line1_valid = 1'b0;
        // cache is empty so the same line comes back from memory
        wait_ok(0, lat);
        expect_equal("slot0_ok latency after reset", miss_lat, lat);
        line0_valid = 1'b1;
        // address move under ok
        slot0_addr  = fresh_addr0();
        @(negedge clk);
        expect_equal("slot0_ok after address change", 0, 32'(slot0_ok));
        wait_ok(0, lat);
        expect_equal("slot0_ok latency after address change", miss_lat, lat + 1);
        line0_tag = slot0_addr[slot0_aw-1:2];
        slot0_cs  = 1'b0;
        @(negedge clk);
        report_test("reset_and_addr_change", e);

        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* rom_2slot_sys.f */
design/rom_mem_pkg.sv
design/rom_data_pkg.sv
design/rom_slot_req.sv
design/rom_slot_arbiter.sv
design/sdram_rd_ctrl.sv
design/rom_2slot_sys.sv
verif/sdram_word_model.sv
verif/rom_2slot_sys_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = rom_2slot_sys_tb
FILELIST = rom_2slot_sys.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
